// File: verilog/hazard_pkg.sv
package hazard_pkg;

	localparam int word_w     = 32;
	localparam int reg_addr_w = 5;

	typedef logic [word_w-1:0]     word_t;
	typedef logic [reg_addr_w-1:0] reg_addr_t;

	// Field positions inside an instruction word
	localparam int opcode_msb = 31;
	localparam int opcode_lsb = 26;
	localparam int rs_msb     = 25;
	localparam int rs_lsb     = 21;
	localparam int rt_msb     = 20;
	localparam int rt_lsb     = 16;
	localparam int funct_msb  = 5;
	localparam int funct_lsb  = 0;

	//////////////////////////////////////////////////
	// Opcodes
	localparam logic [5:0] op_special = 6'b000000;
	localparam logic [5:0] op_regimm  = 6'b000001;
	localparam logic [5:0] op_j       = 6'b000010;
	localparam logic [5:0] op_jal     = 6'b000011;
	localparam logic [5:0] op_beq     = 6'b000100;
	localparam logic [5:0] op_bne     = 6'b000101;
	localparam logic [5:0] op_blez    = 6'b000110;
	localparam logic [5:0] op_bgtz    = 6'b000111;
	localparam logic [5:0] op_addi    = 6'b001000;
	localparam logic [5:0] op_addiu   = 6'b001001;
	localparam logic [5:0] op_slti    = 6'b001010;
	localparam logic [5:0] op_sltiu   = 6'b001011;
	localparam logic [5:0] op_andi    = 6'b001100;
	localparam logic [5:0] op_ori     = 6'b001101;
	localparam logic [5:0] op_xori    = 6'b001110;
	localparam logic [5:0] op_lui     = 6'b001111;
	localparam logic [5:0] op_lb      = 6'b100000;
	localparam logic [5:0] op_lh      = 6'b100001;
	localparam logic [5:0] op_lw      = 6'b100011;
	localparam logic [5:0] op_lbu     = 6'b100100;
	localparam logic [5:0] op_lhu     = 6'b100101;
	localparam logic [5:0] op_sb      = 6'b101000;
	localparam logic [5:0] op_sh      = 6'b101001;
	localparam logic [5:0] op_sw      = 6'b101011;

	//////////////////////////////////////////////////
	// Function codes under op_special
	localparam logic [5:0] fn_sll   = 6'b000000;
	localparam logic [5:0] fn_srl   = 6'b000010;
	localparam logic [5:0] fn_sra   = 6'b000011;
	localparam logic [5:0] fn_sllv  = 6'b000100;
	localparam logic [5:0] fn_srlv  = 6'b000110;
	localparam logic [5:0] fn_srav  = 6'b000111;
	localparam logic [5:0] fn_jr    = 6'b001000;
	localparam logic [5:0] fn_jalr  = 6'b001001;
	localparam logic [5:0] fn_mfhi  = 6'b010000;
	localparam logic [5:0] fn_mthi  = 6'b010001;
	localparam logic [5:0] fn_mflo  = 6'b010010;
	localparam logic [5:0] fn_mtlo  = 6'b010011;
	localparam logic [5:0] fn_mult  = 6'b011000;
	localparam logic [5:0] fn_multu = 6'b011001;
	localparam logic [5:0] fn_div   = 6'b011010;
	localparam logic [5:0] fn_divu  = 6'b011011;
	localparam logic [5:0] fn_add   = 6'b100000;
	localparam logic [5:0] fn_addu  = 6'b100001;
	localparam logic [5:0] fn_sub   = 6'b100010;
	localparam logic [5:0] fn_subu  = 6'b100011;
	localparam logic [5:0] fn_and   = 6'b100100;
	localparam logic [5:0] fn_or    = 6'b100101;
	localparam logic [5:0] fn_xor   = 6'b100110;
	localparam logic [5:0] fn_nor   = 6'b100111;
	localparam logic [5:0] fn_slt   = 6'b101010;
	localparam logic [5:0] fn_sltu  = 6'b101011;

	// rt field under op_regimm
	localparam reg_addr_t rt_bltz = 5'b00000;
	localparam reg_addr_t rt_bgez = 5'b00001;

	localparam reg_addr_t reg_zero = 5'b00000;

endpackage

// File: verilog/instr_class.sv
module instr_class (
	input  hazard_pkg::word_t instr,
	output logic              rs_in_decode,
	output logic              rt_in_decode,
	output logic              rs_in_execute,
	output logic              rt_in_execute,
	output logic              mdu_use,
	output logic              mdu_start
);
	import hazard_pkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	reg_addr_t  rt_code;

	assign opcode  = instr[opcode_msb:opcode_lsb];
	assign funct   = instr[funct_msb:funct_lsb];
	assign rt_code = instr[rt_msb:rt_lsb];

	always_comb
	begin
		rs_in_decode  = 1'b0;
		rt_in_decode  = 1'b0;
		rs_in_execute = 1'b0;
		rt_in_execute = 1'b0;
		mdu_use       = 1'b0;
		mdu_start     = 1'b0;

		// All-zero word is the nop
		if (instr != '0)
		begin
			case (opcode)
				op_special:
				begin
					case (funct)
						fn_add, fn_addu, fn_sub, fn_subu, fn_and, fn_or,
						fn_xor, fn_nor, fn_slt, fn_sltu, fn_sllv, fn_srlv, fn_srav:
						begin
							rs_in_execute = 1'b1;
							rt_in_execute = 1'b1;
						end
						// Shift amount comes from shamt
						fn_sll, fn_srl, fn_sra:
							rt_in_execute = 1'b1;
						fn_jr, fn_jalr:
							rs_in_decode = 1'b1;
						fn_mult, fn_multu, fn_div, fn_divu:
						begin
							rs_in_execute = 1'b1;
							rt_in_execute = 1'b1;
							mdu_use       = 1'b1;
							mdu_start     = 1'b1;
						end
						fn_mthi, fn_mtlo:
						begin
							rs_in_execute = 1'b1;
							mdu_use       = 1'b1;
						end
						fn_mfhi, fn_mflo:
							mdu_use = 1'b1;
						default: ;
					endcase
				end
				op_regimm:
					if (rt_code == rt_bltz || rt_code == rt_bgez)
						rs_in_decode = 1'b1;
				op_beq, op_bne:
				begin
					rs_in_decode = 1'b1;
					rt_in_decode = 1'b1;
				end
				op_blez, op_bgtz:
					rs_in_decode = 1'b1;
				// Base register or ALU source
				op_addi, op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori,
				op_lb, op_lh, op_lw, op_lbu, op_lhu, op_sb, op_sh, op_sw:
					rs_in_execute = 1'b1;
				op_lui, op_j, op_jal: ;
				default: ;
			endcase
		end
	end

endmodule

// File: verilog/stall_unit.sv
module stall_unit (
	input  hazard_pkg::reg_addr_t d_rs_addr,
	input  hazard_pkg::reg_addr_t d_rt_addr,
	input  logic                  d_rs_in_decode,
	input  logic                  d_rt_in_decode,
	input  logic                  d_rs_in_execute,
	input  logic                  d_rt_in_execute,
	input  logic                  d_mdu_use,
	input  logic                  e_mdu_start,
	input  logic                  mdu_busy,
	input  hazard_pkg::reg_addr_t e_dest,
	input  hazard_pkg::reg_addr_t m_dest,
	input  logic                  e_write_en,
	input  logic                  m_write_en,
	input  logic                  e_from_mem,
	input  logic                  m_from_mem,
	output logic                  freeze
);
	import hazard_pkg::*;

	logic e_valid;
	logic m_valid;
	logic rs_hit_e;
	logic rt_hit_e;
	logic rs_hit_m;
	logic rt_hit_m;
	logic mdu_stall;
	logic branch_stall_e;
	logic branch_stall_m;
	logic load_use_stall;

	//////////////////////////////////////////////////
	// Writers in flight

	// A write to register zero is no write at all
	assign e_valid = e_write_en && (e_dest != reg_zero);
	assign m_valid = m_write_en && (m_dest != reg_zero);

	assign rs_hit_e = e_valid && (d_rs_addr == e_dest);
	assign rt_hit_e = e_valid && (d_rt_addr == e_dest);
	assign rs_hit_m = m_valid && (d_rs_addr == m_dest);
	assign rt_hit_m = m_valid && (d_rt_addr == m_dest);

	//////////////////////////////////////////////////
	// Stall conditions

	// HI/LO access waits for the unit, also when a start sits in E
	assign mdu_stall = d_mdu_use && (mdu_busy || e_mdu_start);

	// Branch compare in decode, nothing from E can reach it in time
	assign branch_stall_e = (d_rs_in_decode && rs_hit_e) ||
		(d_rt_in_decode && rt_hit_e);

	// Load data in M is still one cycle away from decode
	assign branch_stall_m = m_from_mem &&
		((d_rs_in_decode && rs_hit_m) || (d_rt_in_decode && rt_hit_m));

	// Classic load-use
	assign load_use_stall = e_from_mem &&
		((d_rs_in_execute && rs_hit_e) || (d_rt_in_execute && rt_hit_e));

	assign freeze = mdu_stall || branch_stall_e || branch_stall_m || load_use_stall;

endmodule

// File: verilog/forward_select.sv
module forward_select #(
	parameter bit take_m_alu = 1'b1,
	parameter bit take_w_alu = 1'b1
) (
	input  hazard_pkg::reg_addr_t src_addr,
	input  hazard_pkg::word_t     reg_value,
	input  hazard_pkg::reg_addr_t m_dest,
	input  hazard_pkg::reg_addr_t w_dest,
	input  logic                  m_write_en,
	input  logic                  w_write_en,
	input  logic                  m_from_mem,
	input  logic                  w_from_mem,
	input  hazard_pkg::word_t     m_alu_result,
	input  hazard_pkg::word_t     w_alu_result,
	input  hazard_pkg::word_t     w_mem_data,
	output hazard_pkg::word_t     operand
);
	import hazard_pkg::*;

	logic src_live;
	logic m_match;
	logic w_match;
	logic m_alu_hit;
	logic w_alu_hit;
	logic w_mem_hit;

	assign src_live = (src_addr != reg_zero);
	assign m_match  = src_live && m_write_en && (m_dest == src_addr);
	assign w_match  = src_live && w_write_en && (w_dest == src_addr);

	assign m_alu_hit = take_m_alu && m_match && !m_from_mem;
	assign w_alu_hit = take_w_alu && w_match && !w_from_mem;
	assign w_mem_hit = w_match && w_from_mem;

	// Youngest writer wins
	always_comb
	begin
		if (m_alu_hit)
			operand = m_alu_result;
		else if (w_alu_hit)
			operand = w_alu_result;
		else if (w_mem_hit)
			operand = w_mem_data;
		else
			operand = reg_value;
	end

endmodule

// File: verilog/hazard_unit.sv
module hazard_unit (
	input  hazard_pkg::word_t     d_instr,
	input  hazard_pkg::word_t     e_instr,
	input  hazard_pkg::reg_addr_t e_rs_addr,
	input  hazard_pkg::reg_addr_t e_rt_addr,
	input  hazard_pkg::reg_addr_t m_rs_addr,
	input  hazard_pkg::reg_addr_t m_rt_addr,
	input  hazard_pkg::word_t     d_rs_value,
	input  hazard_pkg::word_t     d_rt_value,
	input  hazard_pkg::word_t     e_rs_value,
	input  hazard_pkg::word_t     e_rt_value,
	input  hazard_pkg::word_t     m_rs_value,
	input  hazard_pkg::word_t     m_rt_value,
	input  hazard_pkg::reg_addr_t e_dest,
	input  hazard_pkg::reg_addr_t m_dest,
	input  hazard_pkg::reg_addr_t w_dest,
	input  logic                  e_write_en,
	input  logic                  m_write_en,
	input  logic                  w_write_en,
	input  logic                  e_from_mem,
	input  logic                  m_from_mem,
	input  logic                  w_from_mem,
	input  logic                  mdu_busy,
	input  hazard_pkg::word_t     m_alu_result,
	input  hazard_pkg::word_t     w_alu_result,
	input  hazard_pkg::word_t     w_mem_data,
	output hazard_pkg::word_t     d_rs_fwd,
	output hazard_pkg::word_t     d_rt_fwd,
	output hazard_pkg::word_t     e_rs_fwd,
	output hazard_pkg::word_t     e_rt_fwd,
	output hazard_pkg::word_t     m_rs_fwd,
	output hazard_pkg::word_t     m_rt_fwd,
	output logic                  freeze
);
	import hazard_pkg::*;

	reg_addr_t d_rs_addr;
	reg_addr_t d_rt_addr;
	logic      d_rs_in_decode;
	logic      d_rt_in_decode;
	logic      d_rs_in_execute;
	logic      d_rt_in_execute;
	logic      d_mdu_use;
	logic      e_mdu_start;

	assign d_rs_addr = d_instr[rs_msb:rs_lsb];
	assign d_rt_addr = d_instr[rt_msb:rt_lsb];

	//////////////////////////////////////////////////
	// Classification and stall

	instr_class d_class (
		.instr(d_instr),
		.rs_in_decode(d_rs_in_decode), .rt_in_decode(d_rt_in_decode),
		.rs_in_execute(d_rs_in_execute), .rt_in_execute(d_rt_in_execute),
		.mdu_use(d_mdu_use), .mdu_start()
	);

	// Only the MDU start of the execute instruction matters
	instr_class e_class (
		.instr(e_instr),
		.rs_in_decode(), .rt_in_decode(),
		.rs_in_execute(), .rt_in_execute(),
		.mdu_use(), .mdu_start(e_mdu_start)
	);

	stall_unit stall (
		.d_rs_addr(d_rs_addr), .d_rt_addr(d_rt_addr),
		.d_rs_in_decode(d_rs_in_decode), .d_rt_in_decode(d_rt_in_decode),
		.d_rs_in_execute(d_rs_in_execute), .d_rt_in_execute(d_rt_in_execute),
		.d_mdu_use(d_mdu_use), .e_mdu_start(e_mdu_start), .mdu_busy(mdu_busy),
		.e_dest(e_dest), .m_dest(m_dest),
		.e_write_en(e_write_en), .m_write_en(m_write_en),
		.e_from_mem(e_from_mem), .m_from_mem(m_from_mem),
		.freeze(freeze)
	);

	//////////////////////////////////////////////////
	// Operand forwarding

	forward_select #(.take_m_alu(1'b1), .take_w_alu(1'b1)) d_rs_sel (
		.src_addr(d_rs_addr), .reg_value(d_rs_value),
		.m_dest(m_dest), .w_dest(w_dest), .m_write_en(m_write_en), .w_write_en(w_write_en),
		.m_from_mem(m_from_mem), .w_from_mem(w_from_mem), .m_alu_result(m_alu_result),
		.w_alu_result(w_alu_result), .w_mem_data(w_mem_data), .operand(d_rs_fwd)
	);

	forward_select #(.take_m_alu(1'b1), .take_w_alu(1'b1)) d_rt_sel (
		.src_addr(d_rt_addr), .reg_value(d_rt_value),
		.m_dest(m_dest), .w_dest(w_dest), .m_write_en(m_write_en), .w_write_en(w_write_en),
		.m_from_mem(m_from_mem), .w_from_mem(w_from_mem), .m_alu_result(m_alu_result),
		.w_alu_result(w_alu_result), .w_mem_data(w_mem_data), .operand(d_rt_fwd)
	);

	// W ALU results are already in the register file by execute
	forward_select #(.take_m_alu(1'b1), .take_w_alu(1'b0)) e_rs_sel (
		.src_addr(e_rs_addr), .reg_value(e_rs_value),
		.m_dest(m_dest), .w_dest(w_dest), .m_write_en(m_write_en), .w_write_en(w_write_en),
		.m_from_mem(m_from_mem), .w_from_mem(w_from_mem), .m_alu_result(m_alu_result),
		.w_alu_result(w_alu_result), .w_mem_data(w_mem_data), .operand(e_rs_fwd)
	);

	forward_select #(.take_m_alu(1'b1), .take_w_alu(1'b0)) e_rt_sel (
		.src_addr(e_rt_addr), .reg_value(e_rt_value),
		.m_dest(m_dest), .w_dest(w_dest), .m_write_en(m_write_en), .w_write_en(w_write_en),
		.m_from_mem(m_from_mem), .w_from_mem(w_from_mem), .m_alu_result(m_alu_result),
		.w_alu_result(w_alu_result), .w_mem_data(w_mem_data), .operand(e_rt_fwd)
	);

	// Memory stage sees only the W load
	forward_select #(.take_m_alu(1'b0), .take_w_alu(1'b0)) m_rs_sel (
		.src_addr(m_rs_addr), .reg_value(m_rs_value),
		.m_dest(m_dest), .w_dest(w_dest), .m_write_en(m_write_en), .w_write_en(w_write_en),
		.m_from_mem(m_from_mem), .w_from_mem(w_from_mem), .m_alu_result(m_alu_result),
		.w_alu_result(w_alu_result), .w_mem_data(w_mem_data), .operand(m_rs_fwd)
	);

	forward_select #(.take_m_alu(1'b0), .take_w_alu(1'b0)) m_rt_sel (
		.src_addr(m_rt_addr), .reg_value(m_rt_value),
		.m_dest(m_dest), .w_dest(w_dest), .m_write_en(m_write_en), .w_write_en(w_write_en),
		.m_from_mem(m_from_mem), .w_from_mem(w_from_mem), .m_alu_result(m_alu_result),
		.w_alu_result(w_alu_result), .w_mem_data(w_mem_data), .operand(m_rt_fwd)
	);

endmodule

// File: sim/hazard_unit_tb.sv
module hazard_unit_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import hazard_pkg::*;

	localparam int vec_w       = 640;
	localparam int max_vectors = 64;

	logic clk;
	logic arst_n;

	// DUT inputs
	word_t     d_instr;
	word_t     e_instr;
	reg_addr_t e_rs_addr;
	reg_addr_t e_rt_addr;
	reg_addr_t m_rs_addr;
	reg_addr_t m_rt_addr;
	word_t     d_rs_value;
	word_t     d_rt_value;
	word_t     e_rs_value;
	word_t     e_rt_value;
	word_t     m_rs_value;
	word_t     m_rt_value;
	reg_addr_t e_dest;
	reg_addr_t m_dest;
	reg_addr_t w_dest;
	logic      e_write_en;
	logic      m_write_en;
	logic      w_write_en;
	logic      e_from_mem;
	logic      m_from_mem;
	logic      w_from_mem;
	logic      mdu_busy;
	word_t     m_alu_result;
	word_t     w_alu_result;
	word_t     w_mem_data;

	// DUT outputs
	word_t d_rs_fwd;
	word_t d_rt_fwd;
	word_t e_rs_fwd;
	word_t e_rt_fwd;
	word_t m_rs_fwd;
	word_t m_rt_fwd;
	logic  freeze;

	// Raw fields of the current vector
	logic [vec_w-1:0] vectors [0:max_vectors-1];
	logic [7:0]       cur_idx;
	logic [7:0]       e_rs_field;
	logic [7:0]       e_rt_field;
	logic [7:0]       m_rs_field;
	logic [7:0]       m_rt_field;
	logic [7:0]       e_dest_field;
	logic [7:0]       m_dest_field;
	logic [7:0]       w_dest_field;
	logic [27:0]      flag_field;
	logic [3:0]       exp_freeze_field;
	word_t            exp_d_rs;
	word_t            exp_d_rt;
	word_t            exp_e_rs;
	word_t            exp_e_rt;
	word_t            exp_m_rs;
	word_t            exp_m_rt;

	int vector_count   = 0;
	int cycle_count    = 0;
	int cycle_limit    = 12;
	int freeze_errors  = 0;
	int operand_errors = 0;
	int other_errors   = 0;

	hazard_unit UUT (
		.d_instr(d_instr), .e_instr(e_instr),
		.e_rs_addr(e_rs_addr), .e_rt_addr(e_rt_addr),
		.m_rs_addr(m_rs_addr), .m_rt_addr(m_rt_addr),
		.d_rs_value(d_rs_value), .d_rt_value(d_rt_value),
		.e_rs_value(e_rs_value), .e_rt_value(e_rt_value),
		.m_rs_value(m_rs_value), .m_rt_value(m_rt_value),
		.e_dest(e_dest), .m_dest(m_dest), .w_dest(w_dest),
		.e_write_en(e_write_en), .m_write_en(m_write_en), .w_write_en(w_write_en),
		.e_from_mem(e_from_mem), .m_from_mem(m_from_mem), .w_from_mem(w_from_mem),
		.mdu_busy(mdu_busy),
		.m_alu_result(m_alu_result), .w_alu_result(w_alu_result), .w_mem_data(w_mem_data),
		.d_rs_fwd(d_rs_fwd), .d_rt_fwd(d_rt_fwd),
		.e_rs_fwd(e_rs_fwd), .e_rt_fwd(e_rt_fwd),
		.m_rs_fwd(m_rs_fwd), .m_rt_fwd(m_rt_fwd),
		.freeze(freeze)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Reset released on a falling edge after two cycles
	initial
	begin
		arst_n = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count >= cycle_limit)
		begin
			$display("Timeout: run stopped after %0d cycles", cycle_count);
			$display("TEST FAIL");
			$finish;
		end
	end

	function automatic string test_name(input logic [7:0] idx);
		case (idx)
			8'h01: return "load_use_rs";
			8'h02: return "load_use_rt";
			8'h03: return "alu_in_e_no_stall";
			8'h04: return "branch_e_alu_stall";
			8'h05: return "branch_m_alu_forward";
			8'h06: return "branch_m_load_stall";
			8'h07: return "mfhi_mdu_busy";
			8'h08: return "mfhi_mult_in_e";
			8'h09: return "addu_mdu_busy";
			8'h0a: return "addu_mult_in_e";
			8'h0b: return "fwd_m_over_w";
			8'h0c: return "fwd_w_alu";
			8'h0d: return "fwd_w_load";
			8'h0e: return "fwd_no_match";
			8'h0f: return "e_ignores_w_alu";
			8'h10: return "e_takes_w_load";
			8'h11: return "m_takes_w_load";
			8'h12: return "m_ignores_alu";
			8'h13: return "zero_register";
			8'h14: return "disabled_writers";
			8'h15: return "jr_m_load_stall";
			8'h16: return "lui_reads_none";
			default: return "unnamed";
		endcase
	endfunction

	//////////////////////////////////////////////////
	// Vector handling

	task automatic apply_vector(input logic [vec_w-1:0] vec);
		{cur_idx, d_instr, e_instr, e_rs_field, e_rt_field, m_rs_field, m_rt_field,
			d_rs_value, d_rt_value, e_rs_value, e_rt_value, m_rs_value, m_rt_value,
			e_dest_field, m_dest_field, w_dest_field, flag_field,
			m_alu_result, w_alu_result, w_mem_data, exp_freeze_field,
			exp_d_rs, exp_d_rt, exp_e_rs, exp_e_rt, exp_m_rs, exp_m_rt} = vec;
		e_rs_addr  = e_rs_field[4:0];
		e_rt_addr  = e_rt_field[4:0];
		m_rs_addr  = m_rs_field[4:0];
		m_rt_addr  = m_rt_field[4:0];
		e_dest     = e_dest_field[4:0];
		m_dest     = m_dest_field[4:0];
		w_dest     = w_dest_field[4:0];
		// One flag per hex digit
		e_write_en = flag_field[24];
		m_write_en = flag_field[20];
		w_write_en = flag_field[16];
		e_from_mem = flag_field[12];
		m_from_mem = flag_field[8];
		w_from_mem = flag_field[4];
		mdu_busy   = flag_field[0];
	endtask

	task automatic report_operand(input string name, input string port,
		input word_t expected, input word_t actual);
		$display("FAILED %s: %s expected %h, actual %h", name, port, expected, actual);
		operand_errors++;
	endtask

	task automatic check_outputs();
		string name;
		name = test_name(cur_idx);
		if (freeze !== exp_freeze_field[0])
		begin
			$display("FAILED %s: freeze expected %b, actual %b", name,
				exp_freeze_field[0], freeze);
			freeze_errors++;
		end
		if (d_rs_fwd !== exp_d_rs)
			report_operand(name, "d_rs_fwd", exp_d_rs, d_rs_fwd);
		if (d_rt_fwd !== exp_d_rt)
			report_operand(name, "d_rt_fwd", exp_d_rt, d_rt_fwd);
		if (e_rs_fwd !== exp_e_rs)
			report_operand(name, "e_rs_fwd", exp_e_rs, e_rs_fwd);
		if (e_rt_fwd !== exp_e_rt)
			report_operand(name, "e_rt_fwd", exp_e_rt, e_rt_fwd);
		if (m_rs_fwd !== exp_m_rs)
			report_operand(name, "m_rs_fwd", exp_m_rs, m_rs_fwd);
		if (m_rt_fwd !== exp_m_rt)
			report_operand(name, "m_rt_fwd", exp_m_rt, m_rt_fwd);
	endtask

	//////////////////////////////////////////////////
	// Main sequence

	initial
	begin
		apply_vector('0);
		$readmemh("sim/hazard_stimulus.txt", vectors);
		while (vector_count < max_vectors && !$isunknown(vectors[vector_count]))
			vector_count++;
		cycle_limit = 2 + vector_count + 10;
		if (vector_count == 0)
		begin
			$display("No test vectors could be read from sim/hazard_stimulus.txt");
			other_errors++;
		end

		// First vector goes out on the falling edge that ends reset
		@(posedge arst_n);

		for (int i = 0; i < vector_count; i++)
		begin
			apply_vector(vectors[i]);
			@(posedge clk);
			check_outputs();
			@(negedge clk);
		end

		$display("Ran %0d vectors: %0d freeze errors, %0d operand errors, %0d other errors",
			vector_count, freeze_errors, operand_errors, other_errors);
		if (freeze_errors + operand_errors + other_errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// File: sim/hazard_stimulus.txt
// idx d_instr e_instr addr(e_rs e_rt m_rs m_rt) values(d_rs d_rt e_rs e_rt m_rs m_rt) dest(e m w)
// flags(e_we m_we w_we e_mem m_mem w_mem busy) m_alu w_alu w_mem freeze expected(d_rs d_rt e_rs e_rt m_rs m_rt)
010022182000000000000000001111111122222222333333334444444455555555666666660100001001000AAAAAAAABBBBBBBBCCCCCCCC1111111112222222233333333444444445555555566666666
020022182000000000000000001111111122222222333333334444444455555555666666660200001001000AAAAAAAABBBBBBBBCCCCCCCC1111111112222222233333333444444445555555566666666
030022182000000000000000001111111122222222333333334444444455555555666666660100001000000AAAAAAAABBBBBBBBCCCCCCCC0111111112222222233333333444444445555555566666666
041022000400000000000000001111111122222222333333334444444455555555666666660200001000000AAAAAAAABBBBBBBBCCCCCCCC1111111112222222233333333444444445555555566666666
051022000400000000000000001111111122222222333333334444444455555555666666660002000100000AAAAAAAABBBBBBBBCCCCCCCC011111111AAAAAAAA33333333444444445555555566666666
061022000400000000000000001111111122222222333333334444444455555555666666660002000100100AAAAAAAABBBBBBBBCCCCCCCC1111111112222222233333333444444445555555566666666
070000201000000000000000001111111122222222333333334444444455555555666666660000000000001AAAAAAAABBBBBBBBCCCCCCCC1111111112222222233333333444444445555555566666666
080000201000A60018000000001111111122222222333333334444444455555555666666660000000000000AAAAAAAABBBBBBBBCCCCCCCC1111111112222222233333333444444445555555566666666
090022182100000000000000001111111122222222333333334444444455555555666666660000000000001AAAAAAAABBBBBBBBCCCCCCCC0111111112222222233333333444444445555555566666666
0A0022182100A60018000000001111111122222222333333334444444455555555666666660000000000000AAAAAAAABBBBBBBBCCCCCCCC0111111112222222233333333444444445555555566666666
0B0022182000000000000000001111111122222222333333334444444455555555666666660001010110000AAAAAAAABBBBBBBBCCCCCCCC0AAAAAAAA2222222233333333444444445555555566666666
0C0022182000000000000000001111111122222222333333334444444455555555666666660000010010000AAAAAAAABBBBBBBBCCCCCCCC0BBBBBBBB2222222233333333444444445555555566666666
0D0022182000000000000000001111111122222222333333334444444455555555666666660000010010010AAAAAAAABBBBBBBBCCCCCCCC0CCCCCCCC2222222233333333444444445555555566666666
0E0022182000000000000000001111111122222222333333334444444455555555666666660005060110000AAAAAAAABBBBBBBBCCCCCCCC0111111112222222233333333444444445555555566666666
0F0022182000000000070000001111111122222222333333334444444455555555666666660000070010000AAAAAAAABBBBBBBBCCCCCCCC0111111112222222233333333444444445555555566666666
100022182000000000070800001111111122222222333333334444444455555555666666660008070110010AAAAAAAABBBBBBBBCCCCCCCC01111111122222222CCCCCCCCAAAAAAAA5555555566666666
110022182000000000000000091111111122222222333333334444444455555555666666660000090010010AAAAAAAABBBBBBBBCCCCCCCC01111111122222222333333334444444455555555CCCCCCCC
120022182000000000000009091111111122222222333333334444444455555555666666660009090110000AAAAAAAABBBBBBBBCCCCCCCC0111111112222222233333333444444445555555566666666
130000182000000000000000001111111122222222333333334444444455555555666666660000001111010AAAAAAAABBBBBBBBCCCCCCCC0111111112222222233333333444444445555555566666666
140022182000000000010000011111111122222222333333334444444455555555666666660102010001110AAAAAAAABBBBBBBBCCCCCCCC0111111112222222233333333444444445555555566666666
150020000800000000000000001111111122222222333333334444444455555555666666660001000100100AAAAAAAABBBBBBBBCCCCCCCC1111111112222222233333333444444445555555566666666
163C01123400000000000000001111111122222222333333334444444455555555666666660100001001000AAAAAAAABBBBBBBBCCCCCCCC0111111112222222233333333444444445555555566666666

// File: project.f
verilog/hazard_pkg.sv
verilog/instr_class.sv
verilog/stall_unit.sv
verilog/forward_select.sv
verilog/hazard_unit.sv
sim/hazard_unit_tb.sv

// File: Bender.yml
package:
  name: hazard_unit

sources:
  - verilog/hazard_pkg.sv
  - verilog/instr_class.sv
  - verilog/stall_unit.sv
  - verilog/forward_select.sv
  - verilog/hazard_unit.sv
  - target: simulation
    files:
      - sim/hazard_unit_tb.sv
